/* nand_cpu_pkg.sv */
`default_nettype none

package nand_cpu_pkg;

    localparam int DATA_W  = 8;
    localparam int PC_W    = 8;
    localparam int REG_W   = 2;
    localparam int INSTR_W = 16;

    // Codes not listed here retire nothing and write no register.
    typedef enum logic [3:0] {
        OP_NAND = 4'h0,
        OP_ADD  = 4'h1,
        OP_LI   = 4'h2,
        OP_ADDI = 4'h3,
        OP_BEZ  = 4'h4,
        OP_HALT = 4'h5
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_NAND   = 2'd0,
        ALU_ADD    = 2'd1,
        ALU_PASS_B = 2'd2
    } alu_op_e;

    typedef struct packed {
        opcode_e          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [5:0]       unused;
    } r_fmt_t;

    typedef struct packed {
        opcode_e          op;
        logic [REG_W-1:0] rd;
        logic [1:0]       unused;
        logic [7:0]       imm8; // Also the branch target.
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

endpackage

`default_nettype wire

/* nand_cpu_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_cpu_fetch import nand_cpu_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  wire logic               clk,
    input  wire logic               n_rst,
    input  wire logic               i_load_we,
    input  wire logic [PC_W-1:0]    i_load_addr,
    input  wire logic [INSTR_W-1:0] i_load_data,
    input  wire logic               i_run,
    input  wire logic               i_redirect,
    input  wire logic [PC_W-1:0]    i_redirect_pc,
    input  wire logic               i_halt,
    output logic [INSTR_W-1:0]      o_instr,
    output logic [PC_W-1:0]         o_pc,
    output logic                    o_valid,
    output logic                    o_halted
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic [INSTR_W-1:0] imem [IMEM_WORDS];
    logic [PC_W-1:0]    pc;
    logic               running;
    logic               halted;

    // The program can only be changed while nothing is executing.
    always_ff @(posedge clk) begin
        if (i_load_we && !running) begin
            imem[i_load_addr[AW-1:0]] <= i_load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            pc      <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (i_run) begin
            pc      <= '0; // Every run starts from the first word.
            running <= 1'b1;
            halted  <= 1'b0;
        end else if (running) begin
            if (i_halt) begin
                running <= 1'b0;
                halted  <= 1'b1;
            end
            pc <= i_redirect ? i_redirect_pc : pc + 1'b1;
        end
    end

    assign o_instr  = imem[pc[AW-1:0]];
    assign o_pc     = pc;
    assign o_valid  = running;
    assign o_halted = halted;

    // Once halted, no instruction left in the pipeline may halt or branch.
    a_quiet_halted: assert property (@(posedge clk) disable iff (!n_rst)
        o_halted |-> !(i_halt || i_redirect));

endmodule

`default_nettype wire

/* nand_cpu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_cpu_regfile import nand_cpu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              n_rst,
    input  wire logic [REG_W-1:0]  i_rs,
    input  wire logic [REG_W-1:0]  i_rt,
    input  wire logic              i_we,
    input  wire logic [REG_W-1:0]  i_wr_reg,
    input  wire logic [DATA_W-1:0] i_wr_data,
    output logic [DATA_W-1:0]      o_rs_data,
    output logic [DATA_W-1:0]      o_rt_data
);

    localparam int NREGS = 2 ** REG_W;

    logic [DATA_W-1:0] regs [NREGS];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wr_reg] <= i_wr_data;
        end
    end

    // A read of the register being written sees the new value.
    // This covers a producer two slots ahead of its consumer.
    assign o_rs_data = (i_we && i_wr_reg == i_rs) ? i_wr_data : regs[i_rs];
    assign o_rt_data = (i_we && i_wr_reg == i_rt) ? i_wr_data : regs[i_rt];

endmodule

`default_nettype wire

/* nand_cpu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_cpu_decode import nand_cpu_pkg::*; (
    input  wire instr_u            i_instr,
    input  wire logic [PC_W-1:0]   i_pc,
    input  wire logic              i_valid,
    input  wire logic [DATA_W-1:0] i_rs_data,
    input  wire logic [DATA_W-1:0] i_rt_data,
    output logic [REG_W-1:0]       o_rs,
    output logic [REG_W-1:0]       o_rt,
    output logic [REG_W-1:0]       o_rd,
    output logic [DATA_W-1:0]      o_op_a,
    output logic [DATA_W-1:0]      o_op_b,
    output logic [REG_W-1:0]       o_a_reg,
    output logic [REG_W-1:0]       o_b_reg,
    output logic                   o_b_is_reg,
    output alu_op_e                o_alu_op,
    output logic                   o_reg_write,
    output logic                   o_branch,
    output logic                   o_halt,
    output logic [PC_W-1:0]        o_pc,
    output logic                   o_valid
);

    logic rd_as_a; // ADDI and BEZ use rd as their register operand.

    always_comb begin
        rd_as_a     = 1'b0;
        o_b_is_reg  = 1'b0;
        o_alu_op    = ALU_PASS_B;
        o_reg_write = 1'b0;
        o_branch    = 1'b0;
        o_halt      = 1'b0;
        case (i_instr.i_fmt.op)
            OP_NAND: begin
                o_b_is_reg  = 1'b1;
                o_alu_op    = ALU_NAND;
                o_reg_write = 1'b1;
            end
            OP_ADD: begin
                o_b_is_reg  = 1'b1;
                o_alu_op    = ALU_ADD;
                o_reg_write = 1'b1;
            end
            OP_LI:   o_reg_write = 1'b1;
            OP_ADDI: begin
                rd_as_a     = 1'b1;
                o_alu_op    = ALU_ADD;
                o_reg_write = 1'b1;
            end
            OP_BEZ: begin
                rd_as_a  = 1'b1;
                o_branch = 1'b1;
            end
            OP_HALT: o_halt = 1'b1;
            default: ;
        endcase
    end

    assign o_rs    = rd_as_a ? i_instr.i_fmt.rd : i_instr.r_fmt.rs;
    assign o_rt    = i_instr.r_fmt.rt;
    assign o_rd    = i_instr.i_fmt.rd;
    assign o_a_reg = o_rs;
    assign o_b_reg = o_rt;
    assign o_op_a  = i_rs_data;
    assign o_op_b  = o_b_is_reg ? i_rt_data : i_instr.i_fmt.imm8;
    assign o_pc    = i_pc;
    assign o_valid = i_valid;

endmodule

`default_nettype wire

/* nand_cpu_pipe_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module i2d_pr import nand_cpu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               n_rst,
    input  wire logic               i_flush,
    input  wire logic               i_valid,
    input  wire logic [PC_W-1:0]    i_pc,
    input  wire logic [INSTR_W-1:0] i_instr,
    output logic                    o_valid,
    output logic [PC_W-1:0]         o_pc,
    output logic [INSTR_W-1:0]      o_instr
);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid && !i_flush;
            o_pc    <= i_pc;
            o_instr <= i_instr;
        end
    end

endmodule

module d2a_pr import nand_cpu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              n_rst,
    input  wire logic              i_flush,
    input  wire logic              i_valid,
    input  wire logic [PC_W-1:0]   i_pc,
    input  wire logic [REG_W-1:0]  i_rd,
    input  wire logic [DATA_W-1:0] i_op_a,
    input  wire logic [DATA_W-1:0] i_op_b,
    input  wire logic [REG_W-1:0]  i_a_reg,
    input  wire logic [REG_W-1:0]  i_b_reg,
    input  wire logic              i_b_is_reg,
    input  wire alu_op_e           i_alu_op,
    input  wire logic              i_reg_write,
    input  wire logic              i_branch,
    input  wire logic              i_halt,
    output logic                   o_valid,
    output logic [PC_W-1:0]        o_pc,
    output logic [REG_W-1:0]       o_rd,
    output logic [DATA_W-1:0]      o_op_a,
    output logic [DATA_W-1:0]      o_op_b,
    output logic [REG_W-1:0]       o_a_reg,
    output logic [REG_W-1:0]       o_b_reg,
    output logic                   o_b_is_reg,
    output alu_op_e                o_alu_op,
    output logic                   o_reg_write,
    output logic                   o_branch,
    output logic                   o_halt
);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid     <= i_valid && !i_flush;
            o_pc        <= i_pc;
            o_rd        <= i_rd;
            o_op_a      <= i_op_a;
            o_op_b      <= i_op_b;
            o_a_reg     <= i_a_reg;
            o_b_reg     <= i_b_reg;
            o_b_is_reg  <= i_b_is_reg;
            o_alu_op    <= i_alu_op;
            o_reg_write <= i_reg_write;
            o_branch    <= i_branch;
            o_halt      <= i_halt;
        end
    end

    // Only the valid instruction held here can raise a flush from execute.
    a_flush_needs_valid: assert property (@(posedge clk) disable iff (!n_rst)
        i_flush |-> o_valid);

endmodule

module a2w_pr import nand_cpu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              n_rst,
    input  wire logic              i_valid,
    input  wire logic [PC_W-1:0]   i_pc,
    input  wire logic [REG_W-1:0]  i_rd,
    input  wire logic [DATA_W-1:0] i_result,
    input  wire logic              i_reg_write,
    output logic                   o_valid,
    output logic [PC_W-1:0]        o_pc,
    output logic [REG_W-1:0]       o_rd,
    output logic [DATA_W-1:0]      o_result,
    output logic                   o_reg_write
);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid     <= i_valid;
            o_pc        <= i_pc;
            o_rd        <= i_rd;
            o_result    <= i_result;
            o_reg_write <= i_reg_write;
        end
    end

endmodule

`default_nettype wire

/* nand_cpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_cpu_alu import nand_cpu_pkg::*; (
    input  wire logic              i_valid,
    input  wire logic [PC_W-1:0]   i_pc,
    input  wire logic [REG_W-1:0]  i_rd,
    input  wire logic [DATA_W-1:0] i_op_a,
    input  wire logic [DATA_W-1:0] i_op_b,
    input  wire logic [REG_W-1:0]  i_a_reg,
    input  wire logic [REG_W-1:0]  i_b_reg,
    input  wire logic              i_b_is_reg,
    input  wire alu_op_e           i_alu_op,
    input  wire logic              i_reg_write,
    input  wire logic              i_branch,
    input  wire logic              i_halt,
    input  wire logic              i_wb_valid,
    input  wire logic              i_wb_write,
    input  wire logic [REG_W-1:0]  i_wb_reg,
    input  wire logic [DATA_W-1:0] i_wb_data,
    output logic [REG_W-1:0]       o_rd,
    output logic [DATA_W-1:0]      o_result,
    output logic                   o_reg_write,
    output logic [PC_W-1:0]        o_pc,
    output logic                   o_valid,
    output logic                   o_redirect,
    output logic [PC_W-1:0]        o_redirect_pc,
    output logic                   o_halt
);

    logic              wb_hit;
    logic [DATA_W-1:0] a_val;
    logic [DATA_W-1:0] b_val;

    // The instruction just ahead is in writeback and its register write
    // has not landed yet, so its result overrides the decoded operand.
    assign wb_hit = i_wb_valid && i_wb_write;
    assign a_val  = (wb_hit && i_wb_reg == i_a_reg) ? i_wb_data : i_op_a;
    assign b_val  = (wb_hit && i_b_is_reg && i_wb_reg == i_b_reg) ? i_wb_data : i_op_b;

    always_comb begin
        case (i_alu_op)
            ALU_NAND: o_result = ~(a_val & b_val);
            ALU_ADD:  o_result = a_val + b_val; // Wraps modulo 256.
            default:  o_result = b_val;
        endcase
    end

    assign o_rd          = i_rd;
    assign o_reg_write   = i_valid && i_reg_write;
    assign o_pc          = i_pc;
    assign o_valid       = i_valid;
    assign o_redirect    = i_valid && i_branch && (a_val == '0);
    assign o_redirect_pc = PC_W'(i_op_b); // BEZ carries its target as imm8.
    assign o_halt        = i_valid && i_halt;

endmodule

`default_nettype wire

/* nand_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_cpu_top import nand_cpu_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  wire logic               clk,
    input  wire logic               n_rst,
    input  wire logic               i_load_we,
    input  wire logic [PC_W-1:0]    i_load_addr,
    input  wire logic [INSTR_W-1:0] i_load_data,
    input  wire logic               i_run,
    output logic                    o_wb_valid,
    output logic [REG_W-1:0]        o_wb_reg,
    output logic [DATA_W-1:0]       o_wb_data,
    output logic [PC_W-1:0]         o_wb_pc,
    output logic                    o_halted
);

    logic [INSTR_W-1:0] f_instr, d_instr;
    logic [PC_W-1:0]    f_pc, d_pc, dec_pc, a_pc, ex_pc, redirect_pc;
    logic               f_valid, d_valid, dec_valid, a_valid, ex_valid, wb_valid;
    logic [REG_W-1:0]   rs, rt, dec_rd, dec_a_reg, dec_b_reg;
    logic [DATA_W-1:0]  rs_data, rt_data, dec_op_a, dec_op_b;
    logic               dec_b_is_reg, dec_reg_write, dec_branch, dec_halt;
    alu_op_e            dec_alu_op, a_alu_op;
    logic [REG_W-1:0]   a_rd, a_a_reg, a_b_reg, ex_rd;
    logic [DATA_W-1:0]  a_op_a, a_op_b, ex_result;
    logic               a_b_is_reg, a_reg_write, a_branch, a_halt;
    logic               ex_reg_write, redirect, ex_halt, flush, wb_write;

    // A taken branch or a HALT in execute drops the two younger slots.
    assign flush      = redirect || ex_halt;
    assign o_wb_valid = wb_valid && wb_write;

    nand_cpu_fetch #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk, .n_rst, .i_load_we, .i_load_addr, .i_load_data, .i_run,
        .i_redirect(redirect), .i_redirect_pc(redirect_pc), .i_halt(ex_halt),
        .o_instr(f_instr), .o_pc(f_pc), .o_valid(f_valid), .o_halted
    );

    i2d_pr u_i2d (
        .clk, .n_rst, .i_flush(flush), .i_valid(f_valid), .i_pc(f_pc), .i_instr(f_instr),
        .o_valid(d_valid), .o_pc(d_pc), .o_instr(d_instr)
    );

    nand_cpu_decode u_decode (
        .i_instr(d_instr), .i_pc(d_pc), .i_valid(d_valid),
        .i_rs_data(rs_data), .i_rt_data(rt_data),
        .o_rs(rs), .o_rt(rt), .o_rd(dec_rd), .o_op_a(dec_op_a), .o_op_b(dec_op_b),
        .o_a_reg(dec_a_reg), .o_b_reg(dec_b_reg), .o_b_is_reg(dec_b_is_reg),
        .o_alu_op(dec_alu_op), .o_reg_write(dec_reg_write), .o_branch(dec_branch),
        .o_halt(dec_halt), .o_pc(dec_pc), .o_valid(dec_valid)
    );

    nand_cpu_regfile u_regfile (
        .clk, .n_rst, .i_rs(rs), .i_rt(rt), .i_we(o_wb_valid),
        .i_wr_reg(o_wb_reg), .i_wr_data(o_wb_data),
        .o_rs_data(rs_data), .o_rt_data(rt_data)
    );

    d2a_pr u_d2a (
        .clk, .n_rst, .i_flush(flush), .i_valid(dec_valid), .i_pc(dec_pc),
        .i_rd(dec_rd), .i_op_a(dec_op_a), .i_op_b(dec_op_b), .i_a_reg(dec_a_reg),
        .i_b_reg(dec_b_reg), .i_b_is_reg(dec_b_is_reg), .i_alu_op(dec_alu_op),
        .i_reg_write(dec_reg_write), .i_branch(dec_branch), .i_halt(dec_halt),
        .o_valid(a_valid), .o_pc(a_pc), .o_rd(a_rd), .o_op_a(a_op_a), .o_op_b(a_op_b),
        .o_a_reg(a_a_reg), .o_b_reg(a_b_reg), .o_b_is_reg(a_b_is_reg),
        .o_alu_op(a_alu_op), .o_reg_write(a_reg_write), .o_branch(a_branch),
        .o_halt(a_halt)
    );

    nand_cpu_alu u_alu (
        .i_valid(a_valid), .i_pc(a_pc), .i_rd(a_rd), .i_op_a(a_op_a), .i_op_b(a_op_b),
        .i_a_reg(a_a_reg), .i_b_reg(a_b_reg), .i_b_is_reg(a_b_is_reg),
        .i_alu_op(a_alu_op), .i_reg_write(a_reg_write), .i_branch(a_branch),
        .i_halt(a_halt), .i_wb_valid(wb_valid), .i_wb_write(wb_write),
        .i_wb_reg(o_wb_reg), .i_wb_data(o_wb_data),
        .o_rd(ex_rd), .o_result(ex_result), .o_reg_write(ex_reg_write), .o_pc(ex_pc),
        .o_valid(ex_valid), .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_halt(ex_halt)
    );

    a2w_pr u_a2w (
        .clk, .n_rst, .i_valid(ex_valid), .i_pc(ex_pc), .i_rd(ex_rd),
        .i_result(ex_result), .i_reg_write(ex_reg_write),
        .o_valid(wb_valid), .o_pc(o_wb_pc), .o_rd(o_wb_reg), .o_result(o_wb_data),
        .o_reg_write(wb_write)
    );

endmodule

`default_nettype wire

/* tb_nand_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_nand_cpu;
    import nand_cpu_pkg::*;

    localparam int RUN_TIMEOUT  = 500;
    localparam int QUIET_CYCLES = 6;

    logic        clk = 1'b0;
    logic        n_rst;
    logic        i_load_we;
    logic [7:0]  i_load_addr;
    logic [15:0] i_load_data;
    logic        i_run;
    logic        o_wb_valid;
    logic [1:0]  o_wb_reg;
    logic [7:0]  o_wb_data;
    logic [7:0]  o_wb_pc;
    logic        o_halted;

    int          error_count;
    int          check_count;
    logic [15:0] lfsr_state;
    logic [15:0] prog [$];
    logic [7:0]  model_regs [4];
    logic [1:0]  exp_reg [$];
    logic [7:0]  exp_data [$];
    logic [7:0]  exp_pc [$];
    logic [1:0]  act_reg [$];
    logic [7:0]  act_data [$];
    logic [7:0]  act_pc [$];
    int          act_cyc [$];

    nand_cpu_top #(.IMEM_WORDS(256)) uut (
        .clk, .n_rst, .i_load_we, .i_load_addr, .i_load_data, .i_run,
        .o_wb_valid, .o_wb_reg, .o_wb_data, .o_wb_pc, .o_halted
    );

    initial begin
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error [%s] %s: expected %0h, actual %0h", test, what, expected, actual);
        end
    endtask

    // Galois form with the taps of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[14:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return value;
    endfunction

    function automatic logic [15:0] asm_r(input opcode_e op, input logic [1:0] rd,
                                          input logic [1:0] rs, input logic [1:0] rt);
        instr_u w;
        w.r_fmt.op     = op;
        w.r_fmt.rd     = rd;
        w.r_fmt.rs     = rs;
        w.r_fmt.rt     = rt;
        w.r_fmt.unused = '0;
        return w;
    endfunction

    function automatic logic [15:0] asm_i(input opcode_e op, input logic [1:0] rd,
                                          input logic [7:0] imm);
        instr_u w;
        w.i_fmt.op     = op;
        w.i_fmt.rd     = rd;
        w.i_fmt.unused = '0;
        w.i_fmt.imm8   = imm;
        return w;
    endfunction

    task automatic apply_reset();
        n_rst <= 1'b0;
        repeat (2) @(posedge clk);
        n_rst <= 1'b1;
        for (int r = 0; r < 4; r++) begin
            model_regs[r] = '0;
        end
    endtask

    // Executes the program one instruction at a time by the ISA rules.
    task automatic model_program();
        instr_u     w;
        logic [7:0] pc;
        logic [7:0] next_pc;
        logic [7:0] v;
        logic       wr;
        int         steps;
        exp_reg.delete();
        exp_data.delete();
        exp_pc.delete();
        pc = '0;
        for (steps = 0; steps < 256; steps++) begin
            if (pc >= prog.size()) break;
            w       = prog[pc];
            next_pc = pc + 8'd1;
            wr      = 1'b0;
            if (w.i_fmt.op == OP_HALT) break;
            case (w.i_fmt.op)
                OP_NAND: begin
                    v  = ~(model_regs[w.r_fmt.rs] & model_regs[w.r_fmt.rt]);
                    wr = 1'b1;
                end
                OP_ADD: begin
                    v  = model_regs[w.r_fmt.rs] + model_regs[w.r_fmt.rt];
                    wr = 1'b1;
                end
                OP_LI: begin
                    v  = w.i_fmt.imm8;
                    wr = 1'b1;
                end
                OP_ADDI: begin
                    v  = model_regs[w.i_fmt.rd] + w.i_fmt.imm8;
                    wr = 1'b1;
                end
                OP_BEZ: if (model_regs[w.i_fmt.rd] == 8'd0) next_pc = w.i_fmt.imm8;
                default: ;
            endcase
            if (wr) begin
                model_regs[w.i_fmt.rd] = v;
                exp_reg.push_back(w.i_fmt.rd);
                exp_data.push_back(v);
                exp_pc.push_back(pc);
            end
            pc = next_pc;
        end
        if (steps == 256 || pc >= prog.size()) begin
            error_count++;
            $display("The reference model ran off the program without reaching HALT.");
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < prog.size(); a++) begin
            @(posedge clk);
            i_load_we   <= 1'b1;
            i_load_addr <= a[7:0];
            i_load_data <= prog[a];
        end
        @(posedge clk);
        i_load_we <= 1'b0;
    endtask

    task automatic compare_retires(input string name);
        check_value(name, "retire count", exp_pc.size(), act_pc.size());
        for (int k = 0; k < exp_pc.size() && k < act_pc.size(); k++) begin
            check_value(name, $sformatf("reg of retire %0d", k), exp_reg[k], act_reg[k]);
            check_value(name, $sformatf("data of retire %0d", k), exp_data[k], act_data[k]);
            check_value(name, $sformatf("pc of retire %0d", k), exp_pc[k], act_pc[k]);
        end
    endtask

    // Loads, runs to HALT, and checks the retire stream against the model.
    task automatic run_program(input string name);
        int cyc;
        int stray;
        bit done;
        load_program();
        model_program();
        act_reg.delete();
        act_data.delete();
        act_pc.delete();
        act_cyc.delete();
        @(posedge clk);
        i_run <= 1'b1;
        @(posedge clk);
        i_run <= 1'b0;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < RUN_TIMEOUT) begin
            @(negedge clk);
            cyc++;
            if (o_wb_valid) begin
                act_reg.push_back(o_wb_reg);
                act_data.push_back(o_wb_data);
                act_pc.push_back(o_wb_pc);
                act_cyc.push_back(cyc);
            end
            done = o_halted;
        end
        if (!done) begin
            error_count++;
            $display("Test %s timed out: the CPU did not halt within %0d cycles.",
                     name, RUN_TIMEOUT);
        end
        stray = 0;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (o_wb_valid) stray++; // Nothing may retire once halted.
        end
        check_value(name, "retires after halt", 0, stray);
        check_value(name, "o_halted held", 1, o_halted);
        compare_retires(name);
    endtask

    task automatic test_li_order();
        apply_reset();
        @(negedge clk);
        check_value("li_order", "o_wb_valid after reset", 0, o_wb_valid);
        check_value("li_order", "o_halted after reset", 0, o_halted);
        prog = '{asm_i(OP_LI, 2'd0, 8'h3C), asm_i(OP_LI, 2'd1, 8'hA5),
                 asm_i(OP_LI, 2'd2, 8'h00), asm_i(OP_LI, 2'd3, 8'hFF),
                 asm_i(OP_HALT, 2'd0, 8'h00)};
        run_program("li_order");
        // Fetched one cycle after the run strobe, retired three cycles later.
        for (int k = 0; k < act_cyc.size(); k++) begin
            check_value("li_order", $sformatf("cycle of retire %0d", k), 4 + k, act_cyc[k]);
        end
    endtask

    task automatic test_forwarding();
        logic [7:0] a;
        logic [7:0] b;
        a = 8'(lfsr_bits(8));
        b = 8'(lfsr_bits(8));
        prog = '{asm_i(OP_LI, 2'd0, a), asm_i(OP_LI, 2'd1, b),
                 asm_r(OP_NAND, 2'd2, 2'd0, 2'd1), asm_r(OP_ADD, 2'd3, 2'd2, 2'd0),
                 asm_r(OP_ADD, 2'd0, 2'd3, 2'd2), asm_r(OP_NAND, 2'd1, 2'd0, 2'd3),
                 asm_r(OP_ADD, 2'd2, 2'd1, 2'd1), asm_i(OP_HALT, 2'd0, 8'h00)};
        run_program("forwarding");
    endtask

    task automatic test_addi_wrap();
        prog = '{asm_i(OP_LI, 2'd1, 8'hF0), asm_i(OP_ADDI, 2'd1, 8'h07),
                 asm_i(OP_ADDI, 2'd1, 8'h0C), asm_i(OP_ADDI, 2'd1, 8'hFF),
                 asm_i(OP_LI, 2'd2, 8'h80), asm_i(OP_ADDI, 2'd2, 8'h80),
                 asm_i(OP_ADDI, 2'd1, 8'h01), asm_i(OP_HALT, 2'd0, 8'h00)};
        run_program("addi_wrap");
    endtask

    task automatic test_branch();
        int skipped;
        prog = '{asm_i(OP_LI, 2'd0, 8'h00), asm_i(OP_LI, 2'd1, 8'h05),
                 asm_i(OP_BEZ, 2'd0, 8'h06), asm_i(OP_LI, 2'd2, 8'h11),
                 asm_i(OP_LI, 2'd3, 8'h22), asm_i(OP_LI, 2'd2, 8'h33),
                 asm_i(OP_LI, 2'd3, 8'h44), asm_i(OP_BEZ, 2'd1, 8'h02),
                 asm_r(OP_ADD, 2'd2, 2'd3, 2'd1), asm_i(OP_HALT, 2'd0, 8'h00)};
        run_program("branch");
        skipped = 0;
        foreach (act_pc[k]) begin
            if (act_pc[k] inside {8'd3, 8'd4, 8'd5}) skipped++;
        end
        check_value("branch", "retires from skipped slots", 0, skipped);
    endtask

    task automatic test_halt_restart();
        logic [7:0] first_data [$];
        logic [7:0] first_pc [$];
        prog = '{asm_i(OP_LI, 2'd0, 8'h01), asm_i(OP_LI, 2'd1, 8'h02),
                 asm_r(OP_ADD, 2'd2, 2'd0, 2'd1), asm_i(OP_HALT, 2'd0, 8'h00),
                 asm_i(OP_LI, 2'd3, 8'h55), asm_i(OP_LI, 2'd3, 8'h66)};
        run_program("halt_first");
        first_data = act_data;
        first_pc   = act_pc;
        run_program("halt_rerun");
        check_value("halt_rerun", "retire count vs first run", first_pc.size(), act_pc.size());
        for (int k = 0; k < first_pc.size() && k < act_pc.size(); k++) begin
            check_value("halt_rerun", $sformatf("pc of retire %0d", k), first_pc[k], act_pc[k]);
            check_value("halt_rerun", $sformatf("data of retire %0d", k),
                        first_data[k], act_data[k]);
        end
    endtask

    task automatic test_random_mix();
        logic [1:0] kind;
        logic [1:0] rd;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
        for (int m = 0; m < 20; m++) begin
            prog.delete();
            for (int n = 0; n < 8; n++) begin
                kind = 2'(lfsr_bits(2));
                rd   = 2'(lfsr_bits(2));
                rs   = 2'(lfsr_bits(2));
                rt   = 2'(lfsr_bits(2));
                imm  = 8'(lfsr_bits(8));
                case (kind)
                    2'd0:    prog.push_back(asm_i(OP_LI, rd, imm));
                    2'd1:    prog.push_back(asm_r(OP_NAND, rd, rs, rt));
                    2'd2:    prog.push_back(asm_r(OP_ADD, rd, rs, rt));
                    default: prog.push_back(asm_i(OP_ADDI, rd, imm));
                endcase
            end
            prog.push_back(asm_i(OP_HALT, 2'd0, 8'h00));
            run_program($sformatf("random_mix_%0d", m));
        end
    endtask

    initial begin
        n_rst       = 1'b0;
        i_load_we   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        i_run       = 1'b0;
        error_count = 0;
        check_count = 0;
        lfsr_state  = 16'd73;
        test_li_order();
        test_forwarding();
        test_addi_wrap();
        test_branch();
        test_halt_restart();
        test_random_mix();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* nand_cpu.f */
nand_cpu_pkg.sv
nand_cpu_fetch.sv
nand_cpu_regfile.sv
nand_cpu_decode.sv
nand_cpu_pipe_regs.sv
nand_cpu_alu.sv
nand_cpu_top.sv
tb_nand_cpu.sv

/* Bender.yml */
package:
  name: nand_cpu

sources:
  - nand_cpu_pkg.sv
  - nand_cpu_fetch.sv
  - nand_cpu_regfile.sv
  - nand_cpu_decode.sv
  - nand_cpu_pipe_regs.sv
  - nand_cpu_alu.sv
  - nand_cpu_top.sv
  - target: simulation
    files:
      - tb_nand_cpu.sv
